/* hdl/fifo_demo_pkg.sv */
package fifo_demo_pkg;

    //------------------------------------------------------------
    // payload and display types

    // one fifo entry, also one hex digit on the display
    typedef logic [3:0] nibble_t;

    // abcdefgh order: segment a in bit 7, dot in bit 0
    typedef logic [7:0] seg_t;

    // only segment g lit, the dash for an unused slot
    localparam seg_t empty_sign = 8'b0000_0010;

    //------------------------------------------------------------
    // control and status types

    // one-cycle pulses, already gated by full and empty
    typedef struct packed
    {
        logic push;
        logic pop;
    } strobe_t;

    // debug view of one fifo slot
    typedef struct packed
    {
        logic    valid;
        nibble_t data;
    } slot_t;

    typedef struct packed
    {
        logic       full;
        logic       empty;
        logic [3:0] count;
        nibble_t    head;
    } status_t;

endpackage

/* hdl/key_strobe.sv */
`timescale 1ns/1ps

module key_strobe
    import fifo_demo_pkg::*;
(
    input                 clk,
    input                 rst_n,
    input        [1:0]    key,
    input  status_t       status,
    output strobe_t       strobe
);

    // two-stage synchronizer, bit 1 is push and bit 0 is pop
    logic [1:0] key_meta;
    logic [1:0] key_sync;
    logic [1:0] key_prev;
    logic [1:0] key_rise;

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end

    assign key_rise = key_sync & ~key_prev;

    // a press that arrives while the fifo cannot take it is dropped
    always_ff @(posedge clk)
        if (!rst_n)
            strobe <= '0;
        else
        begin
            strobe.push <= key_rise[1] & ~status.full;
            strobe.pop  <= key_rise[0] & ~status.empty;
        end

endmodule

/* hdl/pattern_source.sv */
`timescale 1ns/1ps

module pattern_source
    import fifo_demo_pkg::*;
(
    input             clk,
    input             rst_n,
    input  strobe_t   strobe,
    output nibble_t   write_data
);

    //------------------------------------------------------------
    // fixed scramble sequence, indexed by the push counter

    localparam nibble_t pattern [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb,
        4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha,
        4'hf, 4'h5, 4'h8, 4'h3
    };

    logic [3:0] index;

    // wraps naturally at 16
    always_ff @(posedge clk)
        if (!rst_n)
            index <= '0;
        else if (strobe.push)
            index <= index + 4'd1;

    // data for the next push is ready before the strobe comes
    assign write_data = pattern[index];

endmodule

/* hdl/ff_fifo.sv */
`timescale 1ns/1ps

module ff_fifo
    import fifo_demo_pkg::*;
#(
    parameter depth = 8
)
(
    input                                 clk,
    input                                 rst_n,
    input  strobe_t                       strobe,
    input  nibble_t                       write_data,
    output status_t                       status,
    output slot_t   [depth - 1:0]         slots,
    output logic    [$clog2(depth) - 1:0] wr_ptr,
    output logic    [$clog2(depth) - 1:0] rd_ptr
);

    localparam ptr_w = $clog2(depth);
    localparam logic [ptr_w - 1:0] max_ptr = ptr_w'(depth - 1);

    nibble_t    [depth - 1:0] data;
    logic       [depth - 1:0] valid;
    logic       [3:0]         count;
    logic                     full;
    logic                     empty;

    //------------------------------------------------------------
    // storage, written at wr_ptr

    always_ff @(posedge clk)
        if (strobe.push)
            data[wr_ptr] <= write_data;

    //------------------------------------------------------------
    // pointers and per-slot valid bits

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            valid  <= '0;
        end
        else
        begin
            if (strobe.pop)
            begin
                valid[rd_ptr] <= 1'b0;
                rd_ptr        <= (rd_ptr == max_ptr) ? '0 : rd_ptr + 1'b1;
            end

            if (strobe.push)
            begin
                valid[wr_ptr] <= 1'b1;
                wr_ptr        <= (wr_ptr == max_ptr) ? '0 : wr_ptr + 1'b1;
            end
        end

    //------------------------------------------------------------
    // occupancy with registered full and empty flags
    // simultaneous push and pop leaves all three unchanged

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end
        else if (strobe.push & ~strobe.pop)
        begin
            count <= count + 4'd1;
            empty <= 1'b0;
            full  <= (count == 4'(depth - 1));
        end
        else if (strobe.pop & ~strobe.push)
        begin
            count <= count - 4'd1;
            full  <= 1'b0;
            empty <= (count == 4'd1);
        end

    assign status.full  = full;
    assign status.empty = empty;
    assign status.count = count;
    // head reads zero while nothing is stored
    assign status.head  = empty ? '0 : data[rd_ptr];

    always_comb
        for (int i = 0; i < depth; i++)
        begin
            slots[i].valid = valid[i];
            slots[i].data  = data[i];
        end

endmodule

/* hdl/display_scan.sv */
`timescale 1ns/1ps

module display_scan
    import fifo_demo_pkg::*;
#(
    parameter depth       = 8,
    parameter scan_cycles = 4
)
(
    input                                 clk,
    input                                 rst_n,
    input  slot_t   [depth - 1:0]         slots,
    input  logic    [$clog2(depth) - 1:0] wr_ptr,
    input  logic    [$clog2(depth) - 1:0] rd_ptr,
    output seg_t                          abcdefgh,
    output logic    [depth - 1:0]         digit
);

    localparam ptr_w = $clog2(depth);
    localparam pre_w = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;

    localparam logic [ptr_w - 1:0] last_slot = ptr_w'(depth - 1);
    localparam logic [pre_w - 1:0] last_pre  = pre_w'(scan_cycles - 1);

    logic [pre_w - 1:0] pre;
    logic [ptr_w - 1:0] slot_sel;
    logic               tick;
    slot_t              cur;
    seg_t               seg_next;
    logic [depth - 1:0] digit_next;

    function automatic seg_t hex_font(input nibble_t value);
        case (value)
            4'h0: hex_font = 8'b1111_1100;
            4'h1: hex_font = 8'b0110_0000;
            4'h2: hex_font = 8'b1101_1010;
            4'h3: hex_font = 8'b1111_0010;
            4'h4: hex_font = 8'b0110_0110;
            4'h5: hex_font = 8'b1011_0110;
            4'h6: hex_font = 8'b1011_1110;
            4'h7: hex_font = 8'b1110_0000;
            4'h8: hex_font = 8'b1111_1110;
            4'h9: hex_font = 8'b1111_0110;
            4'ha: hex_font = 8'b1110_1110;
            4'hb: hex_font = 8'b0011_1110;
            4'hc: hex_font = 8'b1001_1100;
            4'hd: hex_font = 8'b0111_1010;
            4'he: hex_font = 8'b1001_1110;
            default: hex_font = 8'b1000_1110;
        endcase
    endfunction

    //------------------------------------------------------------
    // scan timing

    assign tick = (pre == last_pre);

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            pre      <= '0;
            slot_sel <= '0;
        end
        else if (tick)
        begin
            pre      <= '0;
            slot_sel <= (slot_sel == last_slot) ? '0 : slot_sel + 1'b1;
        end
        else
            pre <= pre + 1'b1;

    //------------------------------------------------------------
    // segment pattern for the selected slot

    assign cur = slots[slot_sel];

    always_comb
    begin
        seg_next    = cur.valid ? hex_font(cur.data) : empty_sign;
        seg_next[0] = (slot_sel == wr_ptr) || (slot_sel == rd_ptr);
    end

    // mirrored order, slot 0 sits on the leftmost digit
    always_comb
        for (int j = 0; j < depth; j++)
            digit_next[j] = (slot_sel == ptr_w'(depth - 1 - j));

    always_ff @(posedge clk)
        if (!rst_n)
            digit <= {1'b1, {(depth - 1){1'b0}}};
        else
            digit <= digit_next;

    always_ff @(posedge clk)
        abcdefgh <= seg_next;

endmodule

/* hdl/fifo_demo_top.sv */
`timescale 1ns/1ps

module fifo_demo_top
    import fifo_demo_pkg::*;
#(
    parameter depth       = 8,
    parameter scan_cycles = 4
)
(
    input                         clk,
    input                         rst_n,
    input        [1:0]            key,
    output seg_t                  abcdefgh,
    output logic [depth - 1:0]    digit,
    output status_t               status
);

    strobe_t                      strobe;
    nibble_t                      write_data;
    slot_t   [depth - 1:0]        slots;
    logic    [$clog2(depth) - 1:0] wr_ptr;
    logic    [$clog2(depth) - 1:0] rd_ptr;

    //------------------------------------------------------------
    // input side and data source

    key_strobe i_key_strobe
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .key    (key),
        .status (status),
        .strobe (strobe)
    );

    pattern_source i_pattern_source
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .strobe     (strobe),
        .write_data (write_data)
    );

    //------------------------------------------------------------
    // buffer and display

    ff_fifo #(.depth (depth)) i_fifo
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .strobe     (strobe),
        .write_data (write_data),
        .status     (status),
        .slots      (slots),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr)
    );

    display_scan #(.depth (depth), .scan_cycles (scan_cycles)) i_display
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .slots    (slots),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

/* bench/tb_fifo_demo.sv */
`timescale 1ns/1ps

module tb_fifo_demo
    import fifo_demo_pkg::*;
();

    localparam int depth       = 8;
    localparam int scan_cycles = 4;
    localparam int num_presses = 70;
    localparam int num_scans   = 3;
    // each press takes 12 cycles and each scan check at most two full scans
    localparam longint watchdog_ns =
        2 * (num_presses * 12 + num_scans * depth * scan_cycles * 2) * 20;

    localparam nibble_t table_ref [16] = '{4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
                                           4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3};
    // segments a to g with a in the top bit
    localparam logic [6:0] font_ref [16] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b,
                                             7'h5f, 7'h70, 7'h7f, 7'h7b, 7'h77, 7'h1f,
                                             7'h4e, 7'h3d, 7'h4f, 7'h47};

    logic clk;
    logic rst_n;
    logic [1:0] key;
    seg_t abcdefgh;
    logic [depth - 1:0] digit;
    status_t status;

    nibble_t model_q [$];
    logic    model_valid [depth];
    nibble_t model_data [depth];
    int      model_idx;
    int      model_wr;
    int      model_rd;
    int      errors;
    integer  seed;
    integer  r;

    fifo_demo_top #(.depth (depth), .scan_cycles (scan_cycles)) i_dut
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .status   (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    //------------------------------------------------------------
    // reference model and compare tasks

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic apply_to_model(input logic is_push);
        if (is_push && model_q.size() < depth)
        begin
            model_q.push_back(table_ref[model_idx]);
            model_valid[model_wr] = 1'b1;
            model_data[model_wr]  = table_ref[model_idx];
            model_wr  = (model_wr + 1) % depth;
            model_idx = (model_idx + 1) % 16;
        end
        else if (!is_push && model_q.size() > 0)
        begin
            void'(model_q.pop_front());
            model_valid[model_rd] = 1'b0;
            model_rd = (model_rd + 1) % depth;
        end
    endtask

    // raise a key, hold it, release it and let the FIFO settle
    task automatic press_key(input logic is_push, input int hold);
        key = is_push ? 2'b10 : 2'b01;
        wait_cycles(hold);
        key = 2'b00;
        wait_cycles(6);
        apply_to_model(is_push);
    endtask

    function automatic status_t expected_status();
        status_t s;
        s.full  = (model_q.size() == depth);
        s.empty = (model_q.size() == 0);
        s.count = 4'(model_q.size());
        s.head  = (model_q.size() == 0) ? 4'h0 : model_q[0];
        return s;
    endfunction

    function automatic seg_t expected_seg(input int slot);
        seg_t s;
        s    = model_valid[slot] ? {font_ref[model_data[slot]], 1'b0} : empty_sign;
        s[0] = (slot == model_wr) || (slot == model_rd);
        return s;
    endfunction

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "segment mismatch");
        end
    endtask

    // digit bit j shows slot depth-1-j
    // digits are visited in scan order, leftmost first
    task automatic check_display();
        logic [depth - 1:0] want;
        int                 waited;
        for (int j = depth - 1; j >= 0; j--)
        begin
            want    = '0;
            want[j] = 1'b1;
            waited  = 0;
            @(negedge clk);
            while (digit !== want)
            begin
                waited++;
                if (waited > 2 * depth * scan_cycles)
                begin
                    $display("digit select never reached %b", want);
                    $display("FAIL: see errors above");
                    $fatal(1, "display scan stalled");
                end
                @(negedge clk);
            end
            check_seg($sformatf("abcdefgh slot %0d", depth - 1 - j), abcdefgh,
                      expected_seg(depth - 1 - j));
        end
        wait_cycles(1);
    endtask

    //------------------------------------------------------------
    // directed tests

    task automatic test_reset();
        check_status("status", status, expected_status());
        check_display();
    endtask

    // the ninth press meets a full FIFO and is lost
    task automatic test_fill();
        for (int k = 0; k < depth + 1; k++)
        begin
            press_key(1'b1, 6);
            check_status("status", status, expected_status());
        end
    endtask

    task automatic test_drain();
        for (int k = 0; k < depth + 1; k++)
        begin
            press_key(1'b0, 6);
            check_status("status", status, expected_status());
        end
    endtask

    task automatic test_display();
        repeat (5) press_key(1'b1, 6);
        repeat (2) press_key(1'b0, 6);
        check_status("status", status, expected_status());
        check_display();
    endtask

    task automatic test_wrap();
        for (int k = 0; k < 40; k++)
        begin
            r = $random(seed);
            press_key(r[0], 6);
            check_status("status", status, expected_status());
        end
    endtask

    task automatic test_held_key();
        while (model_q.size() >= depth)
            press_key(1'b0, 6);
        press_key(1'b1, 30);
        check_status("status", status, expected_status());
        check_display();
    endtask

    initial
    begin
        errors    = 0;
        seed      = 54;
        model_idx = 0;
        model_wr  = 0;
        model_rd  = 0;
        for (int i = 0; i < depth; i++)
            model_valid[i] = 1'b0;
        key   = 2'b00;
        rst_n = 1'b0;
        wait_cycles(2);
        rst_n = 1'b1;
        wait_cycles(1);
        test_reset();
        test_fill();
        test_drain();
        test_display();
        test_wrap();
        test_held_key();
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* sources.f */
hdl/fifo_demo_pkg.sv
hdl/key_strobe.sv
hdl/pattern_source.sv
hdl/ff_fifo.sv
hdl/display_scan.sv
hdl/fifo_demo_top.sv
bench/tb_fifo_demo.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_fifo_demo
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
